// File: src/quant_pkg.sv
package quant_pkg;

    // vector geometry
    localparam int num_elems   = 4;
    localparam int tree_levels = $clog2(num_elems);

    // fixed point format of the scale
    localparam int frac_bits  = 16;
    localparam int q_max      = 127;
    // numerator of the reciprocal, 127 * 2^16
    localparam int scale_num  = q_max << frac_bits;
    // one half in scale units, used for rounding
    localparam int round_half = 1 << (frac_bits - 1);

    typedef logic signed [15:0] elem_t;
    // one bit wider so that -32768 has a magnitude
    typedef logic        [16:0] absval_t;
    typedef logic        [23:0] scale_t;
    typedef logic signed [40:0] prod_t;
    typedef logic signed [7:0]  q_t;

    typedef elem_t [num_elems-1:0] vec_t;
    typedef q_t    [num_elems-1:0] qvec_t;
    typedef prod_t [num_elems-1:0] prodvec_t;

    // vector with its max and derived scale
    typedef struct packed {
        vec_t    vec;
        absval_t max_abs;
        scale_t  scale;
    } scaled_beat_t;

    // products before rounding
    typedef struct packed {
        prodvec_t prod;
        absval_t  max_abs;
    } prod_beat_t;

    // int8 result, max_abs kept for dequantization downstream
    typedef struct packed {
        qvec_t   q;
        absval_t max_abs;
    } out_beat_t;

endpackage

// File: src/absmax_tree.sv
`timescale 1ns/1ps

module absmax_tree (
    input  logic                clk,
    input  logic                rst,
    input  logic                advance,
    input  quant_pkg::vec_t     in_vec,
    input  logic                in_valid,
    output quant_pkg::vec_t     out_vec,
    output quant_pkg::absval_t  out_max,
    output logic                out_valid
);

    import quant_pkg::*;

    // per level node maxima, level l uses num_elems >> (l+1) nodes
    absval_t                lvl_max [tree_levels][num_elems/2];
    // copy of the vector that travels with each level
    vec_t                   lvl_vec [tree_levels];
    logic [tree_levels-1:0] lvl_valid;
    absval_t                abs_in  [num_elems];

    function automatic absval_t abs_val(elem_t x);
        logic signed [$bits(absval_t)-1:0] ext;
        ext = $bits(absval_t)'(x);
        return (ext < 0) ? absval_t'(-ext) : absval_t'(ext);
    endfunction

    function automatic absval_t max2(absval_t a, absval_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        for (int e = 0; e < num_elems; e++) begin
            abs_in[e] = abs_val(in_vec[e]);
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            // leaf level compares the absolute values pairwise
            for (int n = 0; n < num_elems / 2; n++) begin
                lvl_max[0][n] <= max2(abs_in[2*n], abs_in[2*n+1]);
            end
            lvl_vec[0] <= in_vec;

            for (int l = 1; l < tree_levels; l++) begin
                for (int n = 0; n < (num_elems >> (l + 1)); n++) begin
                    lvl_max[l][n] <= max2(lvl_max[l-1][2*n], lvl_max[l-1][2*n+1]);
                end
                lvl_vec[l] <= lvl_vec[l-1];
            end
        end
    end

    // valid shifts through the levels with the data
    always_ff @(posedge clk) begin
        if (rst) begin
            lvl_valid <= '0;
        end else if (advance) begin
            if (tree_levels > 1) begin
                lvl_valid <= {lvl_valid[tree_levels-2:0], in_valid};
            end else begin
                lvl_valid <= in_valid;
            end
        end
    end

    assign out_max   = lvl_max[tree_levels-1][0];
    assign out_vec   = lvl_vec[tree_levels-1];
    assign out_valid = lvl_valid[tree_levels-1];

    // max must stay aligned with the vector it came from
    for (genvar e = 0; e < num_elems; e++) begin : g_chk
        a_max_covers: assert property (
            @(posedge clk) disable iff (rst)
            out_valid |-> (out_max >= abs_val(out_vec[e]))
        );
    end

endmodule

// File: src/scale_recip.sv
`timescale 1ns/1ps

module scale_recip (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     advance,
    input  quant_pkg::vec_t          in_vec,
    input  quant_pkg::absval_t       in_max,
    input  logic                     in_valid,
    output quant_pkg::scaled_beat_t  out_beat,
    output logic                     out_valid
);

    import quant_pkg::*;

    scale_t scale_next;

    // floor(127 * 2^16 / max_abs), zero vector gives zero scale
    assign scale_next = (in_max == '0) ? '0 : scale_t'(scale_num) / in_max;

    always_ff @(posedge clk) begin
        if (advance) begin
            out_beat.vec     <= in_vec;
            out_beat.max_abs <= in_max;
            out_beat.scale   <= scale_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    // scale is the exact floor, so max_abs * scale lands within one max_abs
    // below the numerator
    a_scale_floor: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && out_beat.max_abs != '0) |->
            ((48'(out_beat.scale) * 48'(out_beat.max_abs) <= 48'(scale_num)) &&
             (48'(out_beat.scale) * 48'(out_beat.max_abs) + 48'(out_beat.max_abs)
                > 48'(scale_num)))
    );

endmodule

// File: src/scale_mult.sv
`timescale 1ns/1ps

module scale_mult (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     advance,
    input  quant_pkg::scaled_beat_t  in_beat,
    input  logic                     in_valid,
    output quant_pkg::prod_beat_t    out_beat,
    output logic                     out_valid
);

    import quant_pkg::*;

    prodvec_t prod_next;
    prod_t    scale_ext;

    // zero extend so the unsigned scale multiplies as a positive signed value
    assign scale_ext = prod_t'(in_beat.scale);

    always_comb begin
        for (int e = 0; e < num_elems; e++) begin
            // both operands at full product width before the multiply
            prod_next[e] = prod_t'(in_beat.vec[e]) * scale_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_beat.prod    <= prod_next;
            out_beat.max_abs <= in_beat.max_abs;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    // a product never exceeds 127 in magnitude before rounding, since
    // every element is bounded by max_abs
    for (genvar e = 0; e < num_elems; e++) begin : g_chk
        a_prod_range: assert property (
            @(posedge clk) disable iff (rst)
            out_valid |->
                ((out_beat.prod[e] <= prod_t'(scale_num)) &&
                 (out_beat.prod[e] >= -prod_t'(scale_num)))
        );
    end

endmodule

// File: src/round_saturate.sv
`timescale 1ns/1ps

module round_saturate (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  quant_pkg::prod_beat_t   in_beat,
    input  logic                    in_valid,
    output quant_pkg::out_beat_t    out_beat,
    output logic                    out_valid
);

    import quant_pkg::*;

    localparam int pw = $bits(prod_t);

    qvec_t q_next;

    // round half away from zero on the magnitude, then put the sign back
    always_comb begin
        prod_t           p;
        logic            neg;
        logic [pw-1:0]   mag;
        logic [pw-1:0]   rnd;
        q_t              q_mag;

        for (int e = 0; e < num_elems; e++) begin
            p   = in_beat.prod[e];
            neg = p[pw-1];
            mag = neg ? pw'(-p) : pw'(p);
            rnd = (mag + pw'(round_half)) >> frac_bits;

            // clamp symmetric, -128 is never produced
            if (rnd > pw'(q_max)) begin
                q_mag = q_t'(q_max);
            end else begin
                q_mag = q_t'(rnd);
            end

            q_next[e] = neg ? -q_mag : q_mag;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_beat.q       <= q_next;
            out_beat.max_abs <= in_beat.max_abs;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    for (genvar e = 0; e < num_elems; e++) begin : g_chk
        a_no_min: assert property (
            @(posedge clk) disable iff (rst)
            out_valid |-> (out_beat.q[e] != q_t'(-q_max - 1))
        );
    end

endmodule

// File: src/quantizer_top.sv
`timescale 1ns/1ps

module quantizer_top (
    input  logic                  clk,
    input  logic                  rst,
    input  quant_pkg::vec_t       in_vec,
    input  logic                  in_valid,
    output logic                  in_ready,
    output quant_pkg::out_beat_t  out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    import quant_pkg::*;

    logic         advance;

    vec_t         tree_vec;
    absval_t      tree_max;
    logic         tree_valid;

    scaled_beat_t rcp_beat;
    logic         rcp_valid;

    prod_beat_t   mul_beat;
    logic         mul_valid;

    // whole pipeline moves together, holds when the output is stuck
    assign advance  = ~out_valid | out_ready;
    assign in_ready = advance;

    absmax_tree u_tree (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .in_vec    (in_vec),
        .in_valid  (in_valid),
        .out_vec   (tree_vec),
        .out_max   (tree_max),
        .out_valid (tree_valid)
    );

    scale_recip u_recip (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .in_vec    (tree_vec),
        .in_max    (tree_max),
        .in_valid  (tree_valid),
        .out_beat  (rcp_beat),
        .out_valid (rcp_valid)
    );

    scale_mult u_mult (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .in_beat   (rcp_beat),
        .in_valid  (rcp_valid),
        .out_beat  (mul_beat),
        .out_valid (mul_valid)
    );

    round_saturate u_round (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .in_beat   (mul_beat),
        .in_valid  (mul_valid),
        .out_beat  (out_beat),
        .out_valid (out_valid)
    );

endmodule

// File: tb/quantizer_checker.sv
`timescale 1ns/1ps

module quantizer_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  quant_pkg::vec_t       in_vec,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  quant_pkg::out_beat_t  out_beat,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  logic [127:0]          test_name,
    output int                    pass_count,
    output int                    err_count,
    output int                    pending
);

    import quant_pkg::*;

    // one entry per accepted beat, oldest first
    out_beat_t    exp_q   [$];
    logic [127:0] name_q  [$];
    int           acc_q   [$];
    int           stall_q [$];

    int           cycle;
    int           stalls;
    logic         in_reset;
    logic         holding;
    out_beat_t    held_beat;

    // symmetric int8: scale = floor(127*2^16 / max_abs), round half away from zero
    function automatic out_beat_t expect_beat(vec_t v);
        out_beat_t b;
        longint    mx;
        longint    a;
        longint    sc;
        longint    p;
        longint    qv;
        mx = 0;
        for (int e = 0; e < num_elems; e++) begin
            a = longint'(v[e]);
            a = (a < 0) ? -a : a;
            mx = (a > mx) ? a : mx;
        end
        sc = (mx == 0) ? 0 : (longint'(q_max) << frac_bits) / mx;
        for (int e = 0; e < num_elems; e++) begin
            p  = longint'(v[e]) * sc;
            qv = (((p < 0) ? -p : p) + (longint'(1) << (frac_bits - 1))) >> frac_bits;
            qv = (qv > q_max) ? q_max : qv;
            b.q[e] = q_t'((p < 0) ? -qv : qv);
        end
        b.max_abs = absval_t'(mx);
        return b;
    endfunction

    // zero bytes come from the padding of short names
    function automatic string name_str(logic [127:0] n);
        string s;
        s = "";
        for (int i = 15; i >= 0; i--) begin
            if (n[i*8 +: 8] != 8'd0) begin
                s = $sformatf("%s%c", s, n[i*8 +: 8]);
            end
        end
        return s;
    endfunction

    function automatic string beat_str(out_beat_t b);
        return $sformatf("q=(%0d %0d %0d %0d) max_abs=%0d", $signed(b.q[0]),
                         $signed(b.q[1]), $signed(b.q[2]), $signed(b.q[3]), b.max_abs);
    endfunction

    always @(negedge clk) begin
        out_beat_t    exp_b;
        string        nm;
        int           lat;
        int           want;

        if (rst) begin
            in_reset   = 1'b1;
            holding    = 1'b0;
            cycle      = 0;
            stalls     = 0;
            pass_count = 0;
            err_count  = 0;
            pending    = 0;
        end else begin
            if (in_reset) begin
                in_reset = 1'b0;
                if (out_valid === 1'b0 && in_ready === 1'b1) begin
                    $display("pass reset_state");
                    pass_count++;
                end else begin
                    $display("after reset out_valid is not low or in_ready is not high");
                    err_count++;
                end
            end

            if (holding && (out_valid !== 1'b1 || out_beat !== held_beat)) begin
                $display("stalled output beat changed or vanished before it was taken");
                err_count++;
            end

            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output beat appeared with no accepted input waiting for it");
                    err_count++;
                end else begin
                    exp_b = exp_q.pop_front();
                    nm    = name_str(name_q.pop_front());
                    lat   = cycle - acc_q.pop_front();
                    // every stalled cycle in between adds one
                    want  = 5 + stalls - stall_q.pop_front();
                    for (int e = 0; e < num_elems; e++) begin
                        if ($signed(out_beat.q[e]) == -128) begin
                            $display("%s: output element %0d is -128", nm, e);
                            err_count++;
                        end
                    end
                    if (out_beat !== exp_b) begin
                        $display("mismatch %s expected %s actual %s", nm,
                                 beat_str(exp_b), beat_str(out_beat));
                        err_count++;
                    end else if (lat != want) begin
                        $display("%s: output came %0d cycles after input, expected %0d",
                                 nm, lat, want);
                        err_count++;
                    end else begin
                        $display("pass %s %s", nm, beat_str(out_beat));
                        pass_count++;
                    end
                end
            end

            if (in_valid && in_ready) begin
                exp_q.push_back(expect_beat(in_vec));
                name_q.push_back(test_name);
                acc_q.push_back(cycle);
                stall_q.push_back(stalls);
            end

            if (out_valid && !out_ready) begin
                stalls++;
            end
            holding   = out_valid && !out_ready;
            held_beat = out_beat;
            cycle++;
            pending   = exp_q.size();
        end
    end

endmodule

// File: tb/quantizer_tb.sv
`timescale 1ns/1ps

module quantizer_tb;

    import quant_pkg::*;

    typedef struct packed {
        logic [127:0] name;
        vec_t         vec;
        logic         ready;
    } stim_t;

    logic         clk;
    logic         rst;
    vec_t         in_vec;
    logic         in_valid;
    logic         in_ready;
    out_beat_t    out_beat;
    logic         out_valid;
    logic         out_ready;
    logic [127:0] cur_name;

    int           pass_count;
    int           err_count;
    int           pending;

    // 8 directed entries followed by 24 random ones
    stim_t        stim_tbl [32];

    quantizer_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_vec    (in_vec),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    quantizer_checker chk0 (
        .clk        (clk),
        .rst        (rst),
        .in_vec     (in_vec),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .test_name  (cur_name),
        .pass_count (pass_count),
        .err_count  (err_count),
        .pending    (pending)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic vec_t make_vec(int a, int b, int c, int d);
        vec_t v;
        v[0] = elem_t'(a);
        v[1] = elem_t'(b);
        v[2] = elem_t'(c);
        v[3] = elem_t'(d);
        return v;
    endfunction

    task automatic fill_table();
        logic [31:0] r;
        vec_t        v;
        stim_tbl[0] = '{"basic_scale", make_vec(100, -50, 25, 0), 1'b1};
        stim_tbl[1] = '{"zero_vector", make_vec(0, 0, 0, 0), 1'b1};
        stim_tbl[2] = '{"extreme_neg", make_vec(-32768, 32767, 1, -1), 1'b1};
        stim_tbl[3] = '{"extreme_pos", make_vec(32767, -32767, 16384, -16384), 1'b1};
        // max 254 gives a scale of exactly one half
        stim_tbl[4] = '{"round_half", make_vec(254, 3, -3, 1), 1'b1};
        // max 508, scale one quarter
        stim_tbl[5] = '{"round_quarter", make_vec(508, 2, -6, -2), 1'b1};
        stim_tbl[6] = '{"round_neg_max", make_vec(-254, -1, 5, 0), 1'b1};
        stim_tbl[7] = '{"unit_max", make_vec(1, -1, 0, 0), 1'b1};

        r = 32'h5d80_1fb4;
        for (int i = 0; i < 24; i++) begin
            r = xorshift(r);
            v[0] = elem_t'(r[15:0]);
            v[1] = elem_t'(r[31:16]);
            r = xorshift(r);
            v[2] = elem_t'(r[15:0]);
            v[3] = elem_t'(r[31:16]);
            r = xorshift(r);
            // shrink some vectors so small magnitudes show up too
            for (int e = 0; e < num_elems; e++) begin
                v[e] = v[e] >>> r[3:0];
            end
            // ascii digits for the entry number
            stim_tbl[8 + i] = '{{"random_", 8'(48 + i / 10), 8'(48 + i % 10)}, v, r[4]};
        end
    endtask

    initial begin
        int waited;
        bit accepted;
        bit aborted;

        rst       = 1'b1;
        in_vec    = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        cur_name  = '0;
        aborted   = 1'b0;
        fill_table();

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < 32 && !aborted; i++) begin
            in_vec    <= stim_tbl[i].vec;
            cur_name  <= stim_tbl[i].name;
            in_valid  <= 1'b1;
            out_ready <= stim_tbl[i].ready;
            waited   = 0;
            accepted = 1'b0;
            while (!accepted && waited < 50) begin
                @(negedge clk);
                accepted = in_ready;
                @(posedge clk);
                if (!accepted) begin
                    // release the stalled output so the pipeline can move
                    out_ready <= 1'b1;
                end
                waited++;
            end
            if (!accepted) begin
                $display("input beat %0d was not accepted within 50 cycles", i);
                aborted = 1'b1;
            end
        end

        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        if (!aborted) begin
            waited = 0;
            while (pending != 0 && waited < 200) begin
                @(posedge clk);
                waited++;
            end
            if (pending != 0) begin
                $display("timeout: %0d beats still inside the pipeline after 200 cycles",
                         pending);
                aborted = 1'b1;
            end
        end

        $display("tests passed: %0d, errors: %0d", pass_count, err_count);
        if (!aborted && err_count == 0 && pass_count > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: quantizer.f
src/quant_pkg.sv
src/absmax_tree.sv
src/scale_recip.sv
src/scale_mult.sv
src/round_saturate.sv
src/quantizer_top.sv
tb/quantizer_checker.sv
tb/quantizer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the quantizer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module quantizer_tb \
    -f quantizer.f -o quantizer_sim &&
./obj_dir/quantizer_sim | tee /dev/stderr | grep -x "Everything OK" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
